/* build.f */
+incdir+rtl
rtl/uart_line_pkg.sv
rtl/bridge_cmd_pkg.sv
rtl/bridge_wb_port.sv
rtl/cmd_sequencer.sv
rtl/uart_tx_serializer.sv
rtl/uart_rx_sampler.sv
rtl/uart_bridge_top.sv
dv/uart_bridge_sva.sv
dv/tb_uart_bridge.sv

/* Makefile */
SIM      = verilator
TOP      = tb_uart_bridge
FILELIST = build.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0 --top-module $(TOP)
RUNFLAGS = +verilator+error+limit+1000
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_uart_bridge.sv */
`include "uart_bridge_params.svh"

module tb_uart_bridge
  import bridge_cmd_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS = 40;
  localparam int BIT_NS = `UART_BAUD_DIV * CLK_NS;
  localparam int N_CMDS = 16;
  localparam int WD_CYC = N_CMDS * (2 * 11 * `UART_BAUD_DIV + `UART_REPLY_TIMEOUT + 50);

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack;
  logic        tx;
  logic        rx;

  logic [7:0]  frames [$];  // bytes seen by the remote device.
  logic [7:0]  dev_regs [128];
  logic [7:0]  exp_mem [128];
  logic [6:0]  written [$];
  logic        corrupt;
  logic        silent;
  int          err_cnt;
  logic [31:0] rng;

  uart_bridge_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .tx       (tx),
    .rx       (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial
  begin
    repeat (WD_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, a command never completed", WD_CYC);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////
  // wishbone master.

  // called 2 ns after a rising edge, returns at the same phase.
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                           output logic [15:0] rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = dat;
    do
    begin
      @(posedge clk);
      #2;
    end while (!wb_ack);
    rdat = wb_dat_o;  // valid on the ack cycle.
    @(posedge clk);  // ack is taken on this edge.
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [15:0] dat);
    bus_cycle(1'b0, adr, 16'h0000, dat);
  endtask

  task automatic wait_idle(output logic [15:0] st);
    do
      wb_read(reg_status, st);
    while (st[0]);
  endtask

  task automatic run_cmd(input logic [15:0] cmd, output logic [15:0] st);
    wb_write(reg_cmd, cmd);
    wait_idle(st);
  endtask

  task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expect_frame(input logic [7:0] exp, input string what);
    logic [7:0] got;
    if (frames.size() == 0)
    begin
      err_cnt++;
      $display("[ERROR] %0t: no %s frame reached the remote device", $time, what);
    end
    else
    begin
      got = frames.pop_front();
      check_value({8'h00, got}, {8'h00, exp}, {what, " frame"});
    end
  endtask

  ////////////////////
  // remote device.

  task automatic recv_frame(output logic [7:0] b);
    b = 8'h00;
    @(negedge tx);
    #(BIT_NS / 2);  // middle of start bit.
    repeat (8)
    begin
      #(BIT_NS);
      b = {tx, b[7:1]};  // lsb first.
    end
    #(2 * BIT_NS);  // over parity, land mid stop.
  endtask

  task automatic send_reply(input logic [7:0] b, input logic bad_par);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ bad_par, b, 1'b0};
    #(BIT_NS + 2);  // off the clock edge.
    repeat (10)
    begin
      rx    = frame[0];
      frame = frame >> 1;
      #(BIT_NS);
    end
    rx = 1'b1;  // stop bit, line stays idle.
  endtask

  initial
  begin : remote_device
    logic [7:0] b;
    logic [6:0] addr_q;
    logic       data_next;
    addr_q    = 7'd0;
    data_next = 1'b0;
    forever
    begin
      recv_frame(b);
      frames.push_back(b);
      if (data_next)
      begin
        dev_regs[addr_q] = b;
        data_next = 1'b0;
      end
      else if (cmd_op_e'(b[7]) == op_write)
      begin
        addr_q    = b[6:0];
        data_next = 1'b1;
      end
      else if (!silent)
        send_reply(dev_regs[b[6:0]], corrupt);
    end
  end

  ////////////////////
  // stimulus.

  initial
  begin : stimulus
    logic [15:0] st;
    logic [15:0] rd;
    logic [6:0]  addr;
    logic [7:0]  data;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 2'd0;
    wb_dat_i = 16'h0000;
    rx       = 1'b1;
    corrupt  = 1'b0;
    silent   = 1'b0;
    err_cnt  = 0;
    rng      = 32'h9e6b9089;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int i = 0; i < 8; i++)
    begin
      rng  = xorshift32(rng);
      addr = rng[6:0];
      data = rng[15:8];
      exp_mem[addr] = data;
      written.push_back(addr);
      run_cmd({op_write, addr, data}, st);
      expect_frame({op_write, addr}, "address");
      expect_frame(data, "data");
      check_value(st & 16'h000e, 16'h0000, "status after write");
    end

    for (int i = 0; i < 4; i++)
    begin
      addr = written[2 * i];
      run_cmd({op_read, addr, 8'h00}, st);
      expect_frame({op_read, addr}, "address");
      check_value(st & 16'h000e, 16'h0008, "status after read");
      wb_read(reg_rdata, rd);
      check_value(rd, {8'h00, exp_mem[addr]}, "read data");
    end

    // reply with bad parity.
    corrupt = 1'b1;
    addr    = written[1];
    run_cmd({op_read, addr, 8'h00}, st);
    corrupt = 1'b0;
    expect_frame({op_read, addr}, "address");
    check_value(st & 16'h000e, 16'h000a, "status after bad parity");

    // no reply at all.
    silent = 1'b1;
    run_cmd({op_read, addr, 8'h00}, st);
    silent = 1'b0;
    expect_frame({op_read, addr}, "address");
    check_value(st & 16'h000e, 16'h0004, "status after timeout");

    // second command stalls behind the first.
    rng  = xorshift32(rng);
    addr = rng[6:0];
    data = rng[15:8];
    wb_write(reg_cmd, {op_write, addr, data});
    wb_write(reg_cmd, {op_write, ~addr, ~data});
    wait_idle(st);
    expect_frame({op_write, addr}, "address");
    expect_frame(data, "data");
    expect_frame({op_write, ~addr}, "stalled address");
    expect_frame(~data, "stalled data");

    repeat (4) @(posedge clk);
    if (frames.size() != 0)
    begin
      err_cnt++;
      $display("%0d frames appeared on tx that no command asked for", frames.size());
    end
    $display("errors: %0d from checks, %0d from assertions", err_cnt, UUT.u_sva.fail_cnt);
    if (err_cnt == 0 && UUT.u_sva.fail_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* dv/uart_bridge_sva.sv */
`include "uart_bridge_params.svh"

module uart_bridge_sva
  import bridge_cmd_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic       wb_we,
  input logic [1:0] wb_adr,
  input logic       wb_ack,
  input logic       tx,
  input logic       busy,
  input logic       tx_start
);
  timeunit 1ns;
  timeprecision 100ps;

  // cycles from tx_start to the middle of the parity and stop bits.
  localparam int DIV      = `UART_BAUD_DIV;
  localparam int PAR_OFS  = 1 + 9 * DIV + DIV / 2;
  localparam int STOP_OFS = 1 + 10 * DIV + DIV / 2;

  int unsigned fail_cnt;
  logic        cmd_access;

  initial fail_cnt = 0;

  assign cmd_access = wb_cyc && wb_stb && wb_we && (wb_reg_e'(wb_adr) == reg_cmd);

  ////////////////////
  // line side.

  // parity bit and the eight data bits, each taken mid-bit off the line.
  a_parity: assert property (@(posedge clk) disable iff (!rst_n)
    $past(tx_start, PAR_OFS) |->
      ^{tx, $past(tx, DIV), $past(tx, 2 * DIV), $past(tx, 3 * DIV), $past(tx, 4 * DIV),
        $past(tx, 5 * DIV), $past(tx, 6 * DIV), $past(tx, 7 * DIV), $past(tx, 8 * DIV)})
  else
  begin
    fail_cnt++;
    $error("parity bit on tx is not odd parity of the frame data");
  end

  a_stop: assert property (@(posedge clk) disable iff (!rst_n)
    $past(tx_start, STOP_OFS) |-> tx)
  else
  begin
    fail_cnt++;
    $error("stop bit on tx is low");
  end

  ////////////////////
  // wishbone side.

  a_ack_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb))
  else
  begin
    fail_cnt++;
    $error("wb_ack high outside an access");
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> !$past(wb_ack))
  else
  begin
    fail_cnt++;
    $error("wb_ack held for two cycles");
  end

  a_cmd_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack && $past(cmd_access)) |-> !$past(busy))
  else
  begin
    fail_cnt++;
    $error("command write acked while the sequencer was busy");
  end

  // first cycle out of reset.
  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> (tx && !wb_ack))
  else
  begin
    fail_cnt++;
    $error("tx low or wb_ack high right after reset");
  end

endmodule

bind uart_bridge_top uart_bridge_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_adr   (wb_adr),
  .wb_ack   (wb_ack),
  .tx       (tx),
  .busy     (busy),
  .tx_start (tx_start)
);

/* rtl/uart_bridge_top.sv */
`include "uart_bridge_params.svh"

module uart_bridge_top
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [1:0]                   wb_adr,
  input  logic [`BRIDGE_CMD_WIDTH-1:0] wb_dat_i,
  output logic [`BRIDGE_CMD_WIDTH-1:0] wb_dat_o,
  output logic                         wb_ack,
  output logic                         tx,
  input  logic                         rx
);

  logic                         cmd_valid;
  logic [`BRIDGE_CMD_WIDTH-1:0] cmd_word;
  logic                         busy;
  logic                         done;
  logic [2:0]                   done_status;
  logic [7:0]                   read_byte;
  logic                         tx_start;
  logic [7:0]                   tx_byte;
  logic                         tx_busy;
  logic                         rx_valid;
  logic [7:0]                   rx_byte;
  logic                         rx_par_err;
  logic                         rx_active;

  bridge_wb_port u_wb_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack),
    .busy        (busy),
    .done        (done),
    .done_status (done_status),
    .read_byte   (read_byte),
    .cmd_valid   (cmd_valid),
    .cmd_word    (cmd_word)
  );

  cmd_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_word    (cmd_word),
    .busy        (busy),
    .tx_start    (tx_start),
    .tx_byte     (tx_byte),
    .tx_busy     (tx_busy),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .rx_par_err  (rx_par_err),
    .rx_active   (rx_active),
    .done        (done),
    .done_status (done_status),
    .read_byte   (read_byte)
  );

  uart_tx_serializer u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // reply path back into the sequencer.
  uart_rx_sampler u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .rx_par_err (rx_par_err),
    .rx_active  (rx_active)
  );

endmodule

/* rtl/uart_rx_sampler.sv */
`include "uart_bridge_params.svh"

module uart_rx_sampler import uart_line_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  output logic       rx_par_err,
  output logic       rx_active
);

  localparam int BAUD_W = $clog2(`UART_BAUD_DIV);
  localparam int HALF   = `UART_BAUD_DIV / 2;

  rx_state_e         state;
  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic              fall;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_idx;
  logic              bit_end;
  logic              mid_start;

  assign fall      = rx_prev && !rx_sync;
  assign bit_end   = (baud_cnt == BAUD_W'(`UART_BAUD_DIV - 1));
  assign mid_start = (baud_cnt == BAUD_W'(HALF - 1));
  assign rx_active = (state != rxs_idle);

  ////////////////////
  // synchronizer and frame FSM.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      state    <= rxs_idle;
      baud_cnt <= '0;
      bit_idx  <= 3'd0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      rx_prev  <= rx_sync;
      rx_valid <= 1'b0;
      baud_cnt <= (state == rxs_idle || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        rxs_idle:
          if (fall)
            state <= rxs_start;
        rxs_start:
          if (mid_start)
          begin
            baud_cnt <= '0;  // realign to mid-bit.
            bit_idx  <= 3'd0;
            state    <= rx_sync ? rxs_idle : rxs_data;
          end
        rxs_data:
          if (bit_end)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= rxs_parity;
          end
        rxs_parity:
          if (bit_end)
            state <= rxs_stop;
        rxs_stop:
          if (bit_end)
          begin
            rx_valid <= 1'b1;  // middle of stop bit.
            state    <= rxs_idle;
          end
        default:
          state <= rxs_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == rxs_data && bit_end)
      rx_byte <= {rx_sync, rx_byte[7:1]};  // lsb first.
    if (state == rxs_parity && bit_end)
      rx_par_err <= ~^{rx_byte, rx_sync};
  end

endmodule

/* rtl/uart_tx_serializer.sv */
`include "uart_bridge_params.svh"

module uart_tx_serializer import uart_line_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  localparam int BAUD_W = $clog2(`UART_BAUD_DIV);

  tx_state_e         state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_idx;
  logic [7:0]        shift_q;
  logic              par_q;
  logic              bit_end;

  assign bit_end = (baud_cnt == BAUD_W'(`UART_BAUD_DIV - 1));
  assign tx_busy = (state != txs_idle);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= txs_idle;
      baud_cnt <= '0;
      bit_idx  <= 3'd0;
      tx       <= 1'b1;  // line idles high.
    end
    else
    begin
      baud_cnt <= (state == txs_idle || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        txs_idle:
          if (tx_start)
          begin
            tx    <= 1'b0;
            state <= txs_start;
          end
        txs_start:
          if (bit_end)
          begin
            tx      <= shift_q[0];
            bit_idx <= 3'd0;
            state   <= txs_data;
          end
        txs_data:
          if (bit_end)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
            begin
              tx    <= par_q;
              state <= txs_parity;
            end
            else
              tx <= shift_q[1];  // next bit, shift lands this edge.
          end
        txs_parity:
          if (bit_end)
          begin
            tx    <= 1'b1;
            state <= txs_stop;
          end
        txs_stop:
          if (bit_end)
            state <= txs_idle;
        default:
          state <= txs_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == txs_idle && tx_start)
    begin
      shift_q <= tx_byte;
      par_q   <= ~^tx_byte;  // odd parity.
    end
    else if (state == txs_data && bit_end)
      shift_q <= shift_q >> 1;
  end

endmodule

/* rtl/cmd_sequencer.sv */
`include "uart_bridge_params.svh"

module cmd_sequencer import bridge_cmd_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_valid,
  input  logic [`BRIDGE_CMD_WIDTH-1:0] cmd_word,
  output logic                         busy,
  output logic                         tx_start,
  output logic [7:0]                   tx_byte,
  input  logic                         tx_busy,
  input  logic                         rx_valid,
  input  logic [7:0]                   rx_byte,
  input  logic                         rx_par_err,
  input  logic                         rx_active,
  output logic                         done,
  output logic [2:0]                   done_status,
  output logic [7:0]                   read_byte
);

  localparam int TMR_W = $clog2(`UART_REPLY_TIMEOUT + 1);

  seq_state_e                   state;
  cmd_op_e                      op;
  logic [`BRIDGE_CMD_WIDTH-1:0] cmd_q;
  logic [TMR_W-1:0]             timer;
  logic                         tail;
  logic                         frame_done;

  assign op   = cmd_op_e'(cmd_q[`BRIDGE_CMD_WIDTH-1]);
  assign busy = (state != seq_idle);

  // tx_busy only rises the cycle after tx_start.
  assign frame_done = !tx_start && !tx_busy;

  ////////////////////
  // command FSM.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= seq_idle;
      tx_start    <= 1'b0;
      done        <= 1'b0;
      done_status <= 3'b000;
      timer       <= '0;
      tail        <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      done     <= 1'b0;
      case (state)
        seq_idle:
          if (cmd_valid)
          begin
            tx_start <= 1'b1;  // address frame.
            state    <= seq_send_addr;
          end
        seq_send_addr:
          if (frame_done)
          begin
            if (op == op_write)
            begin
              tx_start <= 1'b1;
              state    <= seq_send_data;
            end
            else
            begin
              timer <= TMR_W'(1);
              state <= seq_wait_reply;
            end
          end
        seq_send_data:
          if (tail)
          begin
            tail        <= 1'b0;
            done        <= 1'b1;
            done_status <= 3'b000;
            state       <= seq_idle;
          end
          else if (frame_done)
            tail <= 1'b1;
        seq_wait_reply:
          if (rx_active)
            state <= seq_recv_reply;
          else if (timer == TMR_W'(`UART_REPLY_TIMEOUT - 1))
          begin
            done        <= 1'b1;
            done_status <= 3'b010;  // timeout only.
            state       <= seq_idle;
          end
          else
            timer <= timer + 1'b1;
        seq_recv_reply:
          if (rx_valid)
          begin
            done        <= 1'b1;
            done_status <= {1'b1, 1'b0, rx_par_err};
            state       <= seq_idle;
          end
          else if (!rx_active)
            state <= seq_wait_reply;  // false start, keep waiting.
        default:
          state <= seq_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == seq_idle && cmd_valid)
    begin
      cmd_q   <= cmd_word;
      tx_byte <= cmd_word[`BRIDGE_CMD_WIDTH-1:8];  // rw flag and address.
    end
    else if (state == seq_send_addr && frame_done)
      tx_byte <= cmd_q[7:0];
    if (state == seq_recv_reply && rx_valid)
      read_byte <= rx_byte;
  end

endmodule

/* rtl/bridge_wb_port.sv */
`include "uart_bridge_params.svh"

module bridge_wb_port import bridge_cmd_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [1:0]                   wb_adr,
  input  logic [`BRIDGE_CMD_WIDTH-1:0] wb_dat_i,
  output logic [`BRIDGE_CMD_WIDTH-1:0] wb_dat_o,
  output logic                         wb_ack,
  input  logic                         busy,
  input  logic                         done,
  input  logic [2:0]                   done_status,
  input  logic [7:0]                   read_byte,
  output logic                         cmd_valid,
  output logic [`BRIDGE_CMD_WIDTH-1:0] cmd_word
);

  wb_reg_e                      reg_idx;
  logic                         access;
  logic                         cmd_write;
  logic                         take;
  logic [2:0]                   flags;  // read_done, timeout, parity_err.
  logic [7:0]                   rdata;
  logic [`BRIDGE_CMD_WIDTH-1:0] status_word;

  assign reg_idx   = wb_reg_e'(wb_adr);
  assign access    = wb_cyc && wb_stb && !wb_ack;  // one ack per access.
  assign cmd_write = wb_we && (reg_idx == reg_cmd);

  // command writes stall while a command is in flight.
  assign take = access && (!cmd_write || !busy);

  // busy holds until the result has landed in flags.
  assign status_word = {{(`BRIDGE_CMD_WIDTH-4){1'b0}}, flags, busy || cmd_valid || done};

  ////////////////////
  // handshake and sticky status.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack    <= 1'b0;
      cmd_valid <= 1'b0;
      flags     <= 3'b000;
      rdata     <= 8'h00;
    end
    else
    begin
      wb_ack    <= take;
      cmd_valid <= take && cmd_write;
      if (take && cmd_write)
        flags <= 3'b000;  // new command clears the old result.
      else if (done)
        flags <= done_status;
      if (done && done_status[2])
        rdata <= read_byte;
    end
  end

  ////////////////////
  // data paths.

  always_ff @(posedge clk)
  begin
    if (take && cmd_write)
      cmd_word <= wb_dat_i;
    if (take)
    begin
      case (reg_idx)
        reg_cmd:    wb_dat_o <= cmd_word;
        reg_status: wb_dat_o <= status_word;
        reg_rdata:  wb_dat_o <= {{(`BRIDGE_CMD_WIDTH-8){1'b0}}, rdata};
        default:    wb_dat_o <= '0;
      endcase
    end
  end

endmodule

/* rtl/bridge_cmd_pkg.sv */
package bridge_cmd_pkg;

  // command kind, taken from the top bit of the command word.
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cmd_op_e;

  typedef enum logic [2:0] {
    seq_idle,
    seq_send_addr,
    seq_send_data,
    seq_wait_reply,
    seq_recv_reply
  } seq_state_e;

  // wishbone register map.
  typedef enum logic [1:0] {
    reg_cmd    = 2'd0,
    reg_status = 2'd1,
    reg_rdata  = 2'd2
  } wb_reg_e;

endpackage

/* rtl/uart_line_pkg.sv */
package uart_line_pkg;

  // serializer states.
  typedef enum logic [2:0] {
    txs_idle,
    txs_start,
    txs_data,
    txs_parity,
    txs_stop
  } tx_state_e;

  // sampler states.
  typedef enum logic [2:0] {
    rxs_idle,
    rxs_start,
    rxs_data,
    rxs_parity,
    rxs_stop
  } rx_state_e;

endpackage

/* rtl/uart_bridge_params.svh */
`ifndef UART_BRIDGE_PARAMS_SVH
`define UART_BRIDGE_PARAMS_SVH

// clock cycles per bit, kept short for simulation.
`define UART_BAUD_DIV 8

// cycles to wait for a reply start bit after the address frame.
`define UART_REPLY_TIMEOUT 400

// rw flag, 7-bit address, data byte.
`define BRIDGE_CMD_WIDTH 16

`endif
